/* logic/bpm_pkg.sv */
package bpm_pkg;

	//////////////////////////////////////////////////
	// widths and constants
	//////////////////////////////////////////////////
	localparam int SAMPLE_W   = 16;     // baseline-corrected adc sample
	localparam int POWER_W    = 32;     // sum of squares, wraps mod 2^32
	localparam int N_CH       = 4;      // electrodes a..d

	// overflow threshold, signed compare
	localparam logic signed [SAMPLE_W-1:0] OVF_LEVEL = 16'sh7FF0;

	localparam logic [31:0] PACKET_ID  = 32'h4142504D;   // "ABPM"
	localparam int          PACKET_LEN = 10;             // words per packet

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	// one sample set, a in the top bits
	typedef struct packed {
		logic signed [SAMPLE_W-1:0] a;
		logic signed [SAMPLE_W-1:0] b;
		logic signed [SAMPLE_W-1:0] c;
		logic signed [SAMPLE_W-1:0] d;
	} sample_t;

	// per channel event result
	typedef struct packed {
		logic [SAMPLE_W-1:0] peak;   // largest sample seen
		logic                ovf;    // any sample >= OVF_LEVEL
		logic [POWER_W-1:0]  power;  // sum of squares
	} chan_result_t;

	// slow fifo word, one 32 bit value or two 16 bit halves
	typedef union packed {
		logic [31:0] full;
		struct packed {
			logic [15:0] hi;
			logic [15:0] lo;
		} halves;
	} pkt_word_u;

endpackage

/* logic/chan_stats.sv */
`timescale 1ns/1ns
module chan_stats (
	input  logic                                 clk,
	input  logic                                 RST_EVENT_NO,
	input  logic                                 in_valid,
	input  logic                                 event_end,
	input  logic signed [bpm_pkg::SAMPLE_W-1:0]  sample,
	output bpm_pkg::chan_result_t                result,
	output logic                                 stats_rdy
);
	import bpm_pkg::*;

	// most negative sample, peak search starts here
	localparam logic signed [SAMPLE_W-1:0] PEAK_INIT = {1'b1, {(SAMPLE_W-1){1'b0}}};

	logic signed [SAMPLE_W-1:0] peak_acc;
	logic signed [SAMPLE_W-1:0] peak_nxt;
	logic                       ovf_acc;
	logic                       ovf_nxt;
	logic [POWER_W-1:0]         pow_acc;
	logic [POWER_W-1:0]         pow_nxt;
	logic signed [POWER_W-1:0]  sq;          // sample squared, always >= 0

	//////////////////////////////////////////////////
	// running values including the current sample
	//////////////////////////////////////////////////
	assign sq       = sample * sample;                             // full 32 bit product
	assign peak_nxt = (sample > peak_acc) ? sample : peak_acc;     // signed compare
	assign ovf_nxt  = ovf_acc | (sample >= OVF_LEVEL);
	assign pow_nxt  = pow_acc + $unsigned(sq);                     // wraps, no saturation

	// accumulators and ready pulse
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			peak_acc  <= PEAK_INIT;
			ovf_acc   <= 1'b0;
			pow_acc   <= '0;
			stats_rdy <= 1'b0;
		end else begin
			stats_rdy <= in_valid & event_end;     // one cycle after last sample
			if (in_valid) begin
				if (event_end) begin
					// last sample goes to result, restart for next event
					peak_acc <= PEAK_INIT;
					ovf_acc  <= 1'b0;
					pow_acc  <= '0;
				end else begin
					peak_acc <= peak_nxt;
					ovf_acc  <= ovf_nxt;
					pow_acc  <= pow_nxt;
				end
			end
		end
	end

	// result held until the next event closes
	always_ff @(posedge clk) begin
		if (in_valid && event_end) begin
			result.peak  <= peak_nxt;
			result.ovf   <= ovf_nxt;
			result.power <= pow_nxt;
		end
	end

endmodule

/* logic/result_bank.sv */
`timescale 1ns/1ns
module result_bank (
	input  logic                   clk,
	input  logic                   RST_EVENT_NO,
	input  bpm_pkg::chan_result_t  ch_result [bpm_pkg::N_CH],
	input  logic                   stats_rdy,
	input  logic                   event_end,
	input  logic                   cal_flag,
	output bpm_pkg::chan_result_t  real_res [bpm_pkg::N_CH],
	output logic [bpm_pkg::POWER_W-1:0] cal_power_a,
	output logic [bpm_pkg::POWER_W-1:0] cal_power_b,
	output logic [15:0]            evt_cnt,
	output logic                   evt_done,
	output logic                   is_real
);

	logic cal_evt;   // cal_flag as seen at event_end

	//////////////////////////////////////////////////
	// event bookkeeping
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			cal_evt  <= 1'b0;
			evt_cnt  <= '0;
			evt_done <= 1'b0;
			is_real  <= 1'b0;
		end else begin
			if (event_end)
				cal_evt <= cal_flag;   // level, sampled on last sample
			evt_done <= stats_rdy;     // follows results by one cycle
			if (stats_rdy) begin
				is_real <= ~cal_evt;
				if (!cal_evt)
					evt_cnt <= evt_cnt + 16'd1;   // real events only
			end
		end
	end

	// separate banks, cal events never touch real_res
	always_ff @(posedge clk) begin
		if (stats_rdy) begin
			if (!cal_evt) begin
				real_res <= ch_result;
			end else begin
				cal_power_a <= ch_result[0].power;
				cal_power_b <= ch_result[1].power;
			end
		end
	end

endmodule

/* logic/packet_builder.sv */
`timescale 1ns/1ns
module packet_builder #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic                                clk,
	input  logic                                RST_EVENT_NO,
	input  logic                                evt_done,
	input  logic                                is_real,
	input  logic                                run,
	input  bpm_pkg::chan_result_t               real_res [bpm_pkg::N_CH],
	input  logic [bpm_pkg::POWER_W-1:0]         cal_power_a,
	input  logic [bpm_pkg::POWER_W-1:0]         cal_power_b,
	input  logic [15:0]                         evt_cnt,
	input  logic [$clog2(FIFO_DEPTH):0]         fifo_count,
	output logic [15:0]                         status,
	output logic                                wr_en,
	output bpm_pkg::pkt_word_u                  din
);
	import bpm_pkg::*;

	localparam int CW = $clog2(FIFO_DEPTH) + 1;   // fifo count width
	localparam int IW = $clog2(PACKET_LEN + 1);   // word index width

	logic          fifo_full;
	logic          room;       // space for a whole packet
	logic [IW-1:0] widx;       // next word to load, PID is word 0

	assign fifo_full = (fifo_count == CW'(FIFO_DEPTH));
	assign room      = (fifo_count <= CW'(FIFO_DEPTH - PACKET_LEN));

	// ovf a..d, spare, fifo full, run
	assign status = {real_res[0].ovf, real_res[1].ovf, real_res[2].ovf, real_res[3].ovf,
		10'b0, fifo_full, run};

	//////////////////////////////////////////////////
	// write sequencer, wr_en doubles as busy state
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			wr_en <= 1'b0;
			widx  <= '0;
		end else if (!wr_en) begin
			if (evt_done && is_real && room) begin   // else packet skipped
				wr_en <= 1'b1;
				widx  <= IW'(1);
			end
		end else if (widx == IW'(PACKET_LEN)) begin
			wr_en <= 1'b0;                            // 10 words out
			widx  <= '0;
		end else begin
			widx  <= widx + IW'(1);
		end
	end

	// packet words
	always_ff @(posedge clk) begin
		if (!wr_en) begin
			din.full <= PACKET_ID;   // preloaded while idle
		end else begin
			case (widx)
				IW'(1): begin
					din.halves.hi <= status;
					din.halves.lo <= evt_cnt;
				end
				IW'(2): begin
					din.halves.hi <= real_res[0].peak;
					din.halves.lo <= real_res[1].peak;
				end
				IW'(3): begin
					din.halves.hi <= real_res[2].peak;
					din.halves.lo <= real_res[3].peak;
				end
				IW'(4): din.full <= real_res[0].power;
				IW'(5): din.full <= real_res[1].power;
				IW'(6): din.full <= real_res[2].power;
				IW'(7): din.full <= real_res[3].power;
				IW'(8): din.full <= cal_power_a;     // last cal event
				IW'(9): din.full <= cal_power_b;
				default: din.full <= din.full;      // last word, hold
			endcase
		end
	end

endmodule

/* logic/slow_fifo.sv */
`timescale 1ns/1ns
module slow_fifo #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic                          clk,
	input  logic                          RST_EVENT_NO,
	input  logic                          wr_en,
	input  bpm_pkg::pkt_word_u            din,
	input  logic                          rd,
	output bpm_pkg::pkt_word_u            dout,
	output logic [$clog2(FIFO_DEPTH):0]   count,
	output logic                          full
);
	import bpm_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	pkt_word_u     mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_wr;
	logic          do_rd;

	assign full  = (count == (AW+1)'(FIFO_DEPTH));
	assign do_wr = wr_en & ~full;
	assign do_rd = rd & (count != '0);    // empty read ignored
	assign dout  = mem[rd_ptr];           // head word, fall through

	//////////////////////////////////////////////////
	// pointers and count
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + AW'(1);   // wraps, depth is 2^n
			if (do_rd)
				rd_ptr <= rd_ptr + AW'(1);
			case ({do_wr, do_rd})
				2'b10:   count <= count + (AW+1)'(1);
				2'b01:   count <= count - (AW+1)'(1);
				default: count <= count;          // both or neither
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

endmodule

/* logic/bpm_event_proc.sv */
`timescale 1ns/1ns
module bpm_event_proc #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic                         clk,
	input  logic                         RST_EVENT_NO,
	input  logic                         in_valid,
	input  logic                         event_end,
	input  logic                         cal_flag,
	input  logic                         run,
	input  bpm_pkg::sample_t             samples,
	input  logic                         fifo_rd,
	output bpm_pkg::pkt_word_u           fifo_dout,
	output logic [$clog2(FIFO_DEPTH):0]  fifo_count,
	output logic [15:0]                  status
);
	import bpm_pkg::*;

	logic [N_CH-1:0][SAMPLE_W-1:0] smp;       // sample_t seen as channel array, a on top
	chan_result_t                  ch_res   [N_CH];
	chan_result_t                  real_res [N_CH];
	logic [N_CH-1:0]               ch_rdy;    // all identical, ch 0 used
	logic [POWER_W-1:0]            cal_power_a;
	logic [POWER_W-1:0]            cal_power_b;
	logic [15:0]                   evt_cnt;
	logic                          evt_done;
	logic                          is_real;
	logic                          wr_en;
	pkt_word_u                     din;

	assign smp = samples;

	//////////////////////////////////////////////////
	// per channel stats, index 0 is channel a
	//////////////////////////////////////////////////
	for (genvar i = 0; i < N_CH; i++) begin : g_ch
		chan_stats u_stats (
			.clk(clk), .RST_EVENT_NO(RST_EVENT_NO),
			.in_valid(in_valid), .event_end(event_end),
			.sample(smp[N_CH-1-i]),
			.result(ch_res[i]), .stats_rdy(ch_rdy[i])
		);
	end

	result_bank u_bank (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO),
		.ch_result(ch_res), .stats_rdy(ch_rdy[0]),
		.event_end(event_end), .cal_flag(cal_flag),
		.real_res(real_res), .cal_power_a(cal_power_a), .cal_power_b(cal_power_b),
		.evt_cnt(evt_cnt), .evt_done(evt_done), .is_real(is_real)
	);

	packet_builder #(.FIFO_DEPTH(FIFO_DEPTH)) u_pack (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO),
		.evt_done(evt_done), .is_real(is_real), .run(run),
		.real_res(real_res), .cal_power_a(cal_power_a), .cal_power_b(cal_power_b),
		.evt_cnt(evt_cnt), .fifo_count(fifo_count),
		.status(status), .wr_en(wr_en), .din(din)
	);

	slow_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO),
		.wr_en(wr_en), .din(din), .rd(fifo_rd),
		.dout(fifo_dout), .count(fifo_count),
		.full()          // packer derives full from count
	);

endmodule

/* verif/bpm_asserts.sv */
`timescale 1ns/1ns
module bpm_asserts #(
	parameter int FIFO_DEPTH = 32
) (
	input logic                         clk,
	input logic                         RST_EVENT_NO,
	input logic                         wr_en,
	input bpm_pkg::pkt_word_u           din,
	input logic [15:0]                  evt_cnt,
	input logic [$clog2(FIFO_DEPTH):0]  fifo_count
);
	import bpm_pkg::*;

	int fail_cnt = 0;   // failed assertions so far

	// one burst is exactly one packet
	a_burst_len: assert property (@(posedge clk) disable iff (RST_EVENT_NO)
		$rose(wr_en) |-> wr_en [*PACKET_LEN] ##1 !wr_en)
		else begin
			fail_cnt++;
			$error("wr_en burst is not %0d cycles long", PACKET_LEN);
		end

	// packet opens with the id word and then the count word
	a_first_word: assert property (@(posedge clk) disable iff (RST_EVENT_NO)
		$rose(wr_en) |-> (din.full == PACKET_ID) ##1 (din.halves.lo == evt_cnt))
		else begin
			fail_cnt++;
			$error("packet header words out of order");
		end

	a_no_full_write: assert property (@(posedge clk) disable iff (RST_EVENT_NO)
		wr_en |-> fifo_count != FIFO_DEPTH)   // room check should prevent this
		else begin
			fail_cnt++;
			$error("fifo written while full");
		end

endmodule

bind packet_builder bpm_asserts #(.FIFO_DEPTH(FIFO_DEPTH)) u_asserts (
	.clk(clk),
	.RST_EVENT_NO(RST_EVENT_NO),
	.wr_en(wr_en),
	.din(din),
	.evt_cnt(evt_cnt),
	.fifo_count(fifo_count)
);

/* verif/bpm_checker.sv */
`timescale 1ns/1ns
module bpm_checker #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic                         clk,
	input  logic                         RST_EVENT_NO,
	input  logic                         in_valid,
	input  logic                         event_end,
	input  logic                         cal_flag,
	input  logic                         run,
	input  bpm_pkg::sample_t             samples,
	input  logic                         fifo_rd,
	input  bpm_pkg::pkt_word_u           fifo_dout,
	input  logic [$clog2(FIFO_DEPTH):0]  fifo_count,
	input  logic [15:0]                  status,
	input  logic                         test_done,
	input  int                           test_num,
	input  int                           level,       // expected fifo_count at test end
	output int                           tests_ok,
	output int                           tests_bad,
	output int                           err_total
);
	import bpm_pkg::*;

	logic signed [15:0] pk [N_CH];     // running model per channel
	logic               ov [N_CH];
	logic [31:0]        pw [N_CH];
	logic               r_ovf [N_CH];  // real bank ovf, survives reset like the dut
	logic [31:0]        cal_a;
	logic [31:0]        cal_b;
	logic [15:0]        cnt;           // real events since reset
	logic               real_seen = 1'b0;
	int                 mcnt;          // model fifo level
	int                 rd_pos = 0;    // word index inside packet
	int                 t_err = 0;
	int                 t_words = 0;
	logic [31:0]        expq [$];      // expected fifo words in order

	initial begin
		tests_ok  = 0;
		tests_bad = 0;
		err_total = 0;
	end

	function automatic logic signed [15:0] chan_sample(input sample_t sm, input int ch);
		case (ch)
			0: return sm.a;
			1: return sm.b;
			2: return sm.c;
			default: return sm.d;
		endcase
	endfunction

	task automatic clear_acc();
		for (int ch = 0; ch < N_CH; ch++) begin
			pk[ch] = 16'sh8000;   // most negative
			ov[ch] = 1'b0;
			pw[ch] = '0;
		end
	endtask

	//////////////////////////////////////////////////
	// event model, peak / ovf / sum of squares
	//////////////////////////////////////////////////
	task automatic take_sample();
		logic signed [15:0] s;
		logic signed [31:0] sx;
		for (int ch = 0; ch < N_CH; ch++) begin
			s = chan_sample(samples, ch);
			sx = s;                                 // sign extend before squaring
			if (s > pk[ch])
				pk[ch] = s;
			ov[ch] = ov[ch] | (s >= OVF_LEVEL);
			pw[ch] = pw[ch] + sx * sx;              // mod 2^32
		end
		if (!event_end)
			return;
		if (cal_flag) begin
			cal_a = pw[0];
			cal_b = pw[1];
		end else begin
			cnt = cnt + 16'd1;                      // counted even when skipped
			real_seen = 1'b1;
			for (int ch = 0; ch < N_CH; ch++)
				r_ovf[ch] = ov[ch];
			if (mcnt <= FIFO_DEPTH - PACKET_LEN) begin
				expq.push_back(PACKET_ID);
				expq.push_back({ov[0], ov[1], ov[2], ov[3], 10'b0, 1'b0, run, cnt});
				expq.push_back({pk[0], pk[1]});
				expq.push_back({pk[2], pk[3]});
				for (int ch = 0; ch < N_CH; ch++)
					expq.push_back(pw[ch]);
				expq.push_back(cal_a);
				expq.push_back(cal_b);
				mcnt = mcnt + PACKET_LEN;
			end
		end
		clear_acc();
	endtask

	task automatic check_read();
		logic [31:0] w;
		t_words++;
		if (expq.size() == 0) begin
			$display("unexpected word %h read while no packet was pending", fifo_dout.full);
			t_err++;
			return;
		end
		w = expq.pop_front();
		if (fifo_dout.full !== w) begin
			$display("[FAIL] fifo_dout word %0d: exp %h got %h", rd_pos + 1, w, fifo_dout.full);
			t_err++;
		end
		rd_pos = (rd_pos + 1) % PACKET_LEN;
		if (mcnt > 0)
			mcnt--;
	endtask

	task automatic close_test();
		logic [15:0] st;
		st = {r_ovf[0], r_ovf[1], r_ovf[2], r_ovf[3], 10'b0, mcnt == FIFO_DEPTH, run};
		if (fifo_count !== level) begin
			$display("[FAIL] fifo_count: exp %h got %h", level, fifo_count);
			t_err++;
		end
		if (real_seen && status !== st) begin   // real bank undefined before first event
			$display("[FAIL] status: exp %h got %h", st, status);
			t_err++;
		end
		if (t_err == 0)
			tests_ok++;
		else
			tests_bad++;
		err_total += t_err;
		$display("test %0d: %0d words checked, %0d errors", test_num, t_words, t_err);
		t_err   = 0;
		t_words = 0;
	endtask

	always @(posedge clk) begin
		if (RST_EVENT_NO) begin
			clear_acc();
			mcnt = 0;
			cnt  = '0;
			rd_pos = 0;
			expq.delete();   // fifo emptied too
		end else begin
			if (in_valid)
				take_sample();
			if (fifo_rd && fifo_count != 0)   // empty reads do nothing
				check_read();
			if (test_done)
				close_test();
		end
	end

endmodule

/* verif/bpm_tb.sv */
`timescale 1ns/1ns
module bpm_tb;
	import bpm_pkg::*;

	localparam int FIFO_DEPTH = 32;
	localparam int N_TESTS    = 13;

	// one table row
	typedef struct packed {
		logic [7:0]    len;     // samples in the event
		logic          cal;     // calibration event
		logic          lfsr;    // random samples instead of smp
		logic          rd;      // drain fifo after the event
		logic          run;
		logic          rst;     // reset before the event
		logic [7:0]    level;   // fifo_count expected at test end
		sample_t [3:0] smp;     // explicit samples up to 4
	} evt_t;

	logic                         clk = 1'b0;
	logic                         RST_EVENT_NO;
	logic                         in_valid;
	logic                         event_end;
	logic                         cal_flag;
	logic                         run;
	sample_t                      samples;
	logic                         fifo_rd;
	pkt_word_u                    fifo_dout;
	logic [$clog2(FIFO_DEPTH):0]  fifo_count;
	logic [15:0]                  status;
	logic                         test_done;
	int                           test_num;
	int                           level;
	int                           tests_ok;
	int                           tests_bad;
	int                           err_total;
	logic [15:0]                  lfsr_q = 16'd56;   // seed
	evt_t                         tbl [N_TESTS];
	int                           cyc = 0;
	int                           limit = 0;

	always #4 clk = ~clk;   // 8 ns period

	bpm_event_proc #(.FIFO_DEPTH(FIFO_DEPTH)) uut (.*);
	bpm_checker #(.FIFO_DEPTH(FIFO_DEPTH)) chk (.*);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_word(output logic [15:0] w);
		w = '0;
		for (int b = 0; b < 16; b++) begin
			lfsr_q = lfsr_step(lfsr_q);   // one step per bit
			w = {w[14:0], lfsr_q[0]};
		end
	endtask

	function automatic evt_t make_event(input int len, input bit cal, input bit lfsr,
		input bit rd, input bit run_lvl, input bit rst, input int lvl,
		input sample_t s0, input sample_t s1, input sample_t s2, input sample_t s3);
		evt_t e;
		e.len   = len;
		e.cal   = cal;
		e.lfsr  = lfsr;
		e.rd    = rd;
		e.run   = run_lvl;
		e.rst   = rst;
		e.level = lvl;
		e.smp   = {s3, s2, s1, s0};
		return e;
	endfunction

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////
	task automatic build_table();
		//                  len cal lfsr rd run rst level
		tbl[0]  = make_event(3, 1, 0, 1, 1, 0, 0,   // cal first to define cal powers
			64'h0100_FF00_0200_0010, 64'h0300_0050_FFF0_0020, 64'h0080_0100_0000_0030, 0);
		tbl[1]  = make_event(4, 0, 0, 1, 1, 0, 0,
			64'h1000_F000_0123_0001, 64'h2000_E000_0456_FFFF,
			64'h0800_FFFF_0789_0002, 64'h0400_0001_0ABC_8000);
		tbl[2]  = make_event(3, 0, 0, 1, 0, 0, 0,   // run low
			64'h0010_0020_0030_0040, 64'hFFF0_0021_0031_0041, 64'h0011_FFE0_0032_0042, 0);
		tbl[3]  = make_event(2, 1, 0, 1, 1, 0, 0,   // new cal powers
			64'h0A00_0B00_0C00_0D00, 64'hF600_0500_0000_0100, 0, 0);
		tbl[4]  = make_event(3, 0, 0, 1, 1, 0, 0,   // ovf on b and c
			64'h7FEF_7FF0_0000_8001, 64'h0001_0002_7FFF_8000, 64'h1234_0000_0003_FFFE, 0);
		tbl[5]  = make_event(6, 0, 1, 0, 1, 1, 10, 0, 0, 0, 0);   // count restarts
		tbl[6]  = make_event(8, 0, 1, 0, 1, 0, 20, 0, 0, 0, 0);
		tbl[7]  = make_event(5, 0, 1, 0, 1, 0, 30, 0, 0, 0, 0);
		tbl[8]  = make_event(2, 0, 0, 0, 1, 0, 30,  // skipped for lack of room
			64'h0100_0200_0300_0400, 64'h0500_0600_0700_0800, 0, 0);
		tbl[9]  = make_event(2, 1, 0, 1, 1, 0, 0,
			64'h0020_0040_0060_0080, 64'h00A0_00C0_00E0_0100, 0, 0);
		tbl[10] = make_event(7, 0, 1, 1, 1, 0, 0, 0, 0, 0, 0);   // shows skipped count
		tbl[11] = make_event(12, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0);
		tbl[12] = make_event(1, 0, 1, 1, 1, 0, 0, 0, 0, 0, 0);
	endtask

	task automatic apply_reset();
		RST_EVENT_NO = 1'b1;
		repeat (2) @(negedge clk);
		RST_EVENT_NO = 1'b0;
	endtask

	task automatic send_event(input evt_t e);
		logic [15:0] w [4];
		sample_t     s;
		for (int k = 0; k < e.len; k++) begin
			if (e.lfsr) begin
				for (int ch = 0; ch < 4; ch++)
					draw_word(w[ch]);
				s = {w[0], w[1], w[2], w[3]};
			end else begin
				s = e.smp[k];
			end
			@(negedge clk);
			in_valid  = 1'b1;
			event_end = (k == e.len - 1);
			cal_flag  = e.cal;
			samples   = s;
		end
		@(negedge clk);
		in_valid  = 1'b0;
		event_end = 1'b0;
		repeat (12) @(negedge clk);   // packet fully written by end + 12
	endtask

	task automatic drain_fifo();
		while (fifo_count != 0) begin
			fifo_rd = 1'b1;
			@(negedge clk);
		end
		fifo_rd = 1'b0;
	endtask

	// run limit
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc > limit) begin
			$display("timeout: run went past %0d cycles", limit);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		RST_EVENT_NO = 1'b1;
		in_valid  = 1'b0;
		event_end = 1'b0;
		cal_flag  = 1'b0;
		run       = 1'b0;
		samples   = '0;
		fifo_rd   = 1'b0;
		test_done = 1'b0;
		test_num  = 0;
		level     = 0;
		build_table();
		for (int i = 0; i < N_TESTS; i++)
			limit += 20 + tbl[i].len + (tbl[i].cal ? 0 : 12 * PACKET_LEN);
		limit = 2 * limit;
		repeat (2) @(negedge clk);
		RST_EVENT_NO = 1'b0;

		for (int i = 0; i < N_TESTS; i++) begin
			run = tbl[i].run;
			if (tbl[i].rst)
				apply_reset();
			send_event(tbl[i]);
			if (tbl[i].rd)
				drain_fifo();
			test_num  = i;
			level     = tbl[i].level;
			test_done = 1'b1;   // checker closes the test
			@(negedge clk);
			test_done = 1'b0;
		end

		@(negedge clk);
		$display("summary: %0d tests clean, %0d tests with errors, %0d mismatches, %0d assertion failures",
			tests_ok, tests_bad, err_total, uut.u_pack.u_asserts.fail_cnt);
		if (tests_bad == 0 && err_total == 0 && uut.u_pack.u_asserts.fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* filelist.f */
logic/bpm_pkg.sv
logic/chan_stats.sv
logic/result_bank.sv
logic/packet_builder.sv
logic/slow_fifo.sv
logic/bpm_event_proc.sv
verif/bpm_asserts.sv
verif/bpm_checker.sv
verif/bpm_tb.sv
